// ==== src/henad_pkg.sv ====
// Shared sizes, instruction encodings and pipeline stage records of the three-stage core
// Imported by every RTL module and by the testbench
`default_nettype none

package henad_pkg;

    localparam int XLEN       = 12;
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_DEPTH = 64;
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam int NUM_REGS   = 16;
    localparam int REG_AW     = $clog2(NUM_REGS);
    localparam int NUM_FLAGS  = 4;
    localparam int IMM_W      = 6;

    // Instruction set codes, the register set is active after reset
    localparam logic ISET_R = 1'b0;
    localparam logic ISET_I = 1'b1;

    // Register set opcodes, bits 11..8
    localparam logic [3:0] OPC_ADD  = 4'h0;
    localparam logic [3:0] OPC_SUB  = 4'h1;
    localparam logic [3:0] OPC_AND  = 4'h2;
    localparam logic [3:0] OPC_OR   = 4'h3;
    localparam logic [3:0] OPC_XOR  = 4'h4;
    localparam logic [3:0] OPC_MOV  = 4'h5;
    localparam logic [3:0] OPC_LD   = 4'h6;
    localparam logic [3:0] OPC_ST   = 4'h7;
    localparam logic [3:0] OPC_BCC  = 4'h8;

    // Immediate set opcodes
    localparam logic [3:0] OPC_ADDI = 4'h0;
    localparam logic [3:0] OPC_MOVI = 4'h1;
    localparam logic [3:0] OPC_BCCI = 4'h2;

    // Set switch, same code in both sets, bit 0 picks the new set
    localparam logic [3:0] OPC_SW   = 4'hF;

    // Branch conditions, the immediate set reaches only the first four
    localparam logic [3:0] CC_ALWAYS = 4'h0;
    localparam logic [3:0] CC_Z      = 4'h1;
    localparam logic [3:0] CC_NZ     = 4'h2;
    localparam logic [3:0] CC_C      = 4'h3;
    localparam logic [3:0] CC_NC     = 4'h4;
    localparam logic [3:0] CC_N      = 4'h5;

    // Bit positions in the flag register
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
        logic              iset;
        logic [3:0]        opcode;
        logic [REG_AW-1:0] rd;
        logic              reg_we;
        logic [XLEN-1:0]   src_val;
        logic [XLEN-1:0]   tgt_val;
        logic [XLEN-1:0]   imm;
        logic [3:0]        cc;
    } decode_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   instr;
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } retire_t;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
// Fetch stage: program counter, instruction memory and the fetch-to-decode register
// The memory is filled through the load port while the core is held in reset
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          imem_load,
    input  wire [henad_pkg::IMEM_AW-1:0] imem_addr,
    input  wire [henad_pkg::XLEN-1:0]    imem_data,
    input  wire                          stall,
    input  wire                          redirect,
    input  wire [henad_pkg::XLEN-1:0]    redirect_pc,
    output henad_pkg::fetch_t            fd
);
    import henad_pkg::*;

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;
    logic            run;
    logic            fd_valid;
    logic [XLEN-1:0] fd_pc;
    logic [XLEN-1:0] fd_instr;

    // Program load, one word per cycle during reset
    always_ff @(posedge clk) begin
        if (imem_load && rst) begin
            imem[imem_addr] <= imem_data;
        end
    end

    // First edge after reset only arms the fetch, pc 0 is read on the next one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run      <= 1'b0;
            pc       <= '0;
            fd_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                // Taken branch wins over a stall and drops the word in flight
                pc       <= redirect_pc;
                fd_valid <= 1'b0;
            end else if (!stall) begin
                fd_valid <= run;
                if (run) begin
                    pc <= pc + XLEN'(1);
                end
            end
        end
    end

    // Registered read, address wraps on the low pc bits
    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_pc    <= pc;
            fd_instr <= imem[pc[IMEM_AW-1:0]];
        end
    end

    assign fd = '{valid: fd_valid, pc: fd_pc, instr: fd_instr};

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Decode stage: tracks the current instruction set, splits fields, reads the registers
// and holds the fetched word on a read-after-write hazard with the execute stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire henad_pkg::fetch_t       fd,
    input  wire                          redirect,
    output logic [henad_pkg::REG_AW-1:0] rs_addr,
    output logic [henad_pkg::REG_AW-1:0] rt_addr,
    input  wire [henad_pkg::XLEN-1:0]    rs_data,
    input  wire [henad_pkg::XLEN-1:0]    rt_data,
    output logic                         stall,
    output henad_pkg::decode_t           dx
);
    import henad_pkg::*;

    logic       iset;
    logic [3:0] opcode;
    logic [3:0] cc;
    logic       rs_used;
    logic       rt_used;
    logic       reg_we;
    logic       is_sw;
    logic       rs_hit;
    logic       rt_hit;
    logic       take;
    logic       dx_valid;
    decode_t    dx_next;
    decode_t    dx_q;

    assign opcode = fd.instr[XLEN-1 -: 4];
    assign is_sw  = (opcode == OPC_SW);

    // Field layout and register usage depend on the active set
    always_comb begin
        rs_used = 1'b0;
        rt_used = 1'b0;
        reg_we  = 1'b0;
        if (iset == ISET_R) begin
            rt_addr = fd.instr[7:4];
            rs_addr = fd.instr[3:0];
            cc      = fd.instr[7:4];
            case (opcode)
                OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_XOR: begin
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                    reg_we  = 1'b1;
                end
                OPC_MOV, OPC_LD: begin
                    rs_used = 1'b1;
                    reg_we  = 1'b1;
                end
                OPC_ST: begin
                    rs_used = 1'b1;
                    rt_used = 1'b1;
                end
                OPC_BCC: rs_used = 1'b1;
                default: begin
                end
            endcase
        end else begin
            // Only r0..r3 reachable, no source register
            rt_addr = REG_AW'(fd.instr[7:6]);
            rs_addr = '0;
            cc      = 4'(fd.instr[7:6]);
            case (opcode)
                OPC_ADDI: begin
                    rt_used = 1'b1;
                    reg_we  = 1'b1;
                end
                OPC_MOVI: reg_we = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Producer still in execute, its result is visible through the bypass one cycle later
    assign rs_hit = rs_used && (rs_addr == dx.rd);
    assign rt_hit = rt_used && (rt_addr == dx.rd);
    assign stall  = fd.valid && dx.valid && dx.reg_we && (rs_hit || rt_hit);
    assign take   = fd.valid && !stall && !redirect;

    always_comb begin
        dx_next.valid   = take;
        dx_next.pc      = fd.pc;
        dx_next.instr   = fd.instr;
        dx_next.iset    = iset;
        dx_next.opcode  = opcode;
        dx_next.rd      = rt_addr;
        dx_next.reg_we  = reg_we;
        dx_next.src_val = rs_data;
        dx_next.tgt_val = rt_data;
        dx_next.imm     = {{(XLEN-IMM_W){fd.instr[IMM_W-1]}}, fd.instr[IMM_W-1:0]};
        dx_next.cc      = cc;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iset     <= ISET_R;
            dx_valid <= 1'b0;
        end else begin
            dx_valid <= dx_next.valid;
            // A squashed switch never reaches execute and leaves the set alone
            if (take && is_sw) begin
                iset <= fd.instr[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        dx_q <= dx_next;
    end

    always_comb begin
        dx       = dx_q;
        dx.valid = dx_valid;
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// General register file, two read ports and one write port fed by the retire record
// A read of the register being written returns the new value in the same cycle
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [henad_pkg::REG_AW-1:0]  rs_addr,
    input  wire [henad_pkg::REG_AW-1:0]  rt_addr,
    output logic [henad_pkg::XLEN-1:0]   rs_data,
    output logic [henad_pkg::XLEN-1:0]   rt_data,
    input  wire henad_pkg::retire_t      wb
);
    import henad_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    assign wr_en = wb.valid && wb.we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // Write-through bypass
    assign rs_data = (wr_en && (wb.rd == rs_addr)) ? wb.wdata : regs[rs_addr];
    assign rt_data = (wr_en && (wb.rd == rt_addr)) ? wb.wdata : regs[rt_addr];

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// Execute stage: ALU, flag register, branch resolution and data memory
// Every valid decode record leaves through the registered retire output
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        rst,
    input  wire henad_pkg::decode_t    dx,
    output logic                       redirect,
    output logic [henad_pkg::XLEN-1:0] redirect_pc,
    output henad_pkg::retire_t         retire
);
    import henad_pkg::*;

    logic [XLEN-1:0]      dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]   dmem_addr;
    logic [NUM_FLAGS-1:0] flags;
    logic [NUM_FLAGS-1:0] alu_flags;
    logic                 flag_we;
    logic [XLEN-1:0]      add_b;
    logic [XLEN:0]        sum;
    logic [XLEN:0]        diff;
    logic                 add_ovf;
    logic                 sub_ovf;
    logic [XLEN-1:0]      result;
    logic                 is_st;
    logic                 is_branch;
    logic                 cond_ok;
    logic                 retire_valid;
    retire_t              retire_next;
    retire_t              retire_q;

    assign dmem_addr = dx.src_val[DMEM_AW-1:0];

    // One adder for ADD and ADDI
    assign add_b   = (dx.iset == ISET_I) ? dx.imm : dx.src_val;
    assign sum     = {1'b0, dx.tgt_val} + {1'b0, add_b};
    assign diff    = {1'b0, dx.tgt_val} - {1'b0, dx.src_val};
    assign add_ovf = (dx.tgt_val[XLEN-1] == add_b[XLEN-1]) &&
                     (sum[XLEN-1] != dx.tgt_val[XLEN-1]);
    assign sub_ovf = (dx.tgt_val[XLEN-1] != dx.src_val[XLEN-1]) &&
                     (diff[XLEN-1] != dx.tgt_val[XLEN-1]);

    always_comb begin
        result            = '0;
        flag_we           = 1'b0;
        is_st             = 1'b0;
        is_branch         = 1'b0;
        redirect_pc       = dx.src_val;
        alu_flags[FLAG_C] = 1'b0;
        alu_flags[FLAG_V] = 1'b0;
        if (dx.iset == ISET_R) begin
            case (dx.opcode)
                OPC_ADD: begin
                    result            = sum[XLEN-1:0];
                    alu_flags[FLAG_C] = sum[XLEN];
                    alu_flags[FLAG_V] = add_ovf;
                    flag_we           = 1'b1;
                end
                OPC_SUB: begin
                    // Top bit of the difference is the borrow
                    result            = diff[XLEN-1:0];
                    alu_flags[FLAG_C] = diff[XLEN];
                    alu_flags[FLAG_V] = sub_ovf;
                    flag_we           = 1'b1;
                end
                OPC_AND: begin
                    result  = dx.tgt_val & dx.src_val;
                    flag_we = 1'b1;
                end
                OPC_OR: begin
                    result  = dx.tgt_val | dx.src_val;
                    flag_we = 1'b1;
                end
                OPC_XOR: begin
                    result  = dx.tgt_val ^ dx.src_val;
                    flag_we = 1'b1;
                end
                OPC_MOV: result = dx.src_val;
                OPC_LD:  result = dmem[dmem_addr];
                OPC_ST:  is_st = 1'b1;
                OPC_BCC: is_branch = 1'b1;
                default: begin
                end
            endcase
        end else begin
            case (dx.opcode)
                OPC_ADDI: begin
                    result            = sum[XLEN-1:0];
                    alu_flags[FLAG_C] = sum[XLEN];
                    alu_flags[FLAG_V] = add_ovf;
                    flag_we           = 1'b1;
                end
                OPC_MOVI: result = dx.imm;
                OPC_BCCI: begin
                    is_branch   = 1'b1;
                    redirect_pc = dx.pc + dx.imm;
                end
                default: begin
                end
            endcase
        end
        alu_flags[FLAG_Z] = (result == '0);
        alu_flags[FLAG_N] = result[XLEN-1];
    end

    // Conditions test the architectural flags, already updated by the previous instruction
    always_comb begin
        case (dx.cc)
            CC_ALWAYS: cond_ok = 1'b1;
            CC_Z:      cond_ok = flags[FLAG_Z];
            CC_NZ:     cond_ok = !flags[FLAG_Z];
            CC_C:      cond_ok = flags[FLAG_C];
            CC_NC:     cond_ok = !flags[FLAG_C];
            CC_N:      cond_ok = flags[FLAG_N];
            default:   cond_ok = 1'b0;
        endcase
    end

    assign redirect = dx.valid && is_branch && cond_ok;

    assign retire_next = '{valid: dx.valid, pc: dx.pc, instr: dx.instr,
                           we: dx.reg_we, rd: dx.rd, wdata: result};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags        <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_next.valid;
            if (dx.valid && flag_we) begin
                flags <= alu_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dx.valid && is_st) begin
            dmem[dmem_addr] <= dx.tgt_val;
        end
        retire_q <= retire_next;
    end

    always_comb begin
        retire       = retire_q;
        retire.valid = retire_valid;
    end

endmodule

`default_nettype wire

// ==== src/henad_core.sv ====
// Three-stage core top level, connects fetch, decode, execute and the register file
// The retire record is both the write-back path and the observation port
`timescale 1ns/1ps
`default_nettype none

module henad_core (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          imem_load,
    input  wire [henad_pkg::IMEM_AW-1:0] imem_addr,
    input  wire [henad_pkg::XLEN-1:0]    imem_data,
    output henad_pkg::retire_t           retire
);
    import henad_pkg::*;

    fetch_t            fd;
    decode_t           dx;
    logic              stall;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic [REG_AW-1:0] rs_addr;
    logic [REG_AW-1:0] rt_addr;
    logic [XLEN-1:0]   rs_data;
    logic [XLEN-1:0]   rt_data;

    fetch_stage i_fetch_stage (
        .clk         (clk),
        .rst         (rst),
        .imem_load   (imem_load),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fd          (fd)
    );

    decode_stage i_decode_stage (
        .clk      (clk),
        .rst      (rst),
        .fd       (fd),
        .redirect (redirect),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .stall    (stall),
        .dx       (dx)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (retire)
    );

    execute_stage i_execute_stage (
        .clk         (clk),
        .rst         (rst),
        .dx          (dx),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .retire      (retire)
    );

endmodule

`default_nettype wire

// ==== sim/henad_core_props.sv ====
// Concurrent checks on pipeline control, bound into the core top level
// Reports only through assertion failures
`timescale 1ns/1ps
`default_nettype none

module henad_core_props (
    input wire                     clk,
    input wire                     rst,
    input wire henad_pkg::fetch_t  fd,
    input wire                     stall,
    input wire                     redirect,
    input wire henad_pkg::retire_t retire
);
    import henad_pkg::*;

    // Word behind a taken branch is dropped
    redirect_clears_fd: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !fd.valid)
        else $error("fd.valid still high after redirect");

    retire_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(retire.valid))
        else $error("retire.valid unknown after reset");

    // A branch writes no register, so it never resolves while decode waits on a producer
    stall_not_redirect: assert property (@(posedge clk) disable iff (rst)
        !(stall && redirect))
        else $error("stall and redirect high in the same cycle");

endmodule

bind henad_core henad_core_props i_henad_core_props (
    .clk      (clk),
    .rst      (rst),
    .fd       (fd),
    .stall    (stall),
    .redirect (redirect),
    .retire   (retire)
);

`default_nettype wire

// ==== sim/henad_core_tb.sv ====
// Testbench for the three-stage core: random programs per test, checked retire by retire
// against an in-order architectural model
`timescale 1ns/1ps
`default_nettype none

module henad_core_tb;
    import henad_pkg::*;

    localparam int  NUM_TESTS   = 5;
    localparam int  MAX_RETIRE  = 330;
    localparam int  LOAD_CYCLES = IMEM_DEPTH + 10;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (MAX_RETIRE * 8 + LOAD_CYCLES) * 100;

    logic                clk;
    logic                rst;
    logic                imem_load;
    logic [IMEM_AW-1:0]  imem_addr;
    logic [XLEN-1:0]     imem_data;
    retire_t             retire;

    logic [XLEN-1:0] prog [64];
    logic [XLEN-1:0] mreg [NUM_REGS];
    logic [XLEN-1:0] mdmem [DMEM_DEPTH];
    logic [3:0]      mflags;
    logic            miset;
    logic [XLEN-1:0] mpc;
    int              errors;
    int              checks;

    henad_core i_henad_core (
        .clk       (clk),
        .rst       (rst),
        .imem_load (imem_load),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_val(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic cond_holds(logic [3:0] cc);
        case (cc)
            CC_ALWAYS: return 1'b1;
            CC_Z:      return mflags[FLAG_Z];
            CC_NZ:     return !mflags[FLAG_Z];
            CC_C:      return mflags[FLAG_C];
            CC_NC:     return !mflags[FLAG_C];
            CC_N:      return mflags[FLAG_N];
            default:   return 1'b0;
        endcase
    endfunction

    // Executes the instruction at the model pc and returns what it should retire
    task automatic model_step(output logic [XLEN-1:0] pc_o, output logic [XLEN-1:0] instr_o,
                              output logic we_o, output logic [3:0] rd_o,
                              output logic [XLEN-1:0] wd_o);
        logic [XLEN-1:0] instr;
        logic [3:0]      opc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN:0]   wide;
        logic [XLEN-1:0] npc;
        logic            c;
        logic            v;
        logic            fl;
        instr   = prog[mpc[5:0]];
        opc     = instr[11:8];
        pc_o    = mpc;
        instr_o = instr;
        npc     = mpc + 12'd1;
        we_o    = 1'b0;
        fl      = 1'b0;
        res     = '0;
        c       = 1'b0;
        v       = 1'b0;
        if (miset == ISET_R) begin
            rd_o = instr[7:4];
            a    = mreg[instr[7:4]];
            b    = mreg[instr[3:0]];
        end else begin
            rd_o = {2'b00, instr[7:6]};
            a    = mreg[{2'b00, instr[7:6]}];
            b    = {{6{instr[5]}}, instr[5:0]};
        end
        if (opc == OPC_SW) begin
            miset = instr[0];
        end else if (miset == ISET_R) begin
            case (opc)
                OPC_ADD, OPC_SUB: begin
                    wide = (opc == OPC_ADD) ? ({1'b0, a} + {1'b0, b}) : ({1'b0, a} - {1'b0, b});
                    res  = wide[XLEN-1:0];
                    c    = wide[XLEN];
                    if (opc == OPC_ADD)
                        v = (a[11] == b[11]) && (res[11] != a[11]);
                    else
                        v = (a[11] != b[11]) && (res[11] != a[11]);
                    we_o = 1'b1;
                    fl   = 1'b1;
                end
                OPC_AND, OPC_OR, OPC_XOR: begin
                    res  = (opc == OPC_AND) ? (a & b) : (opc == OPC_OR) ? (a | b) : (a ^ b);
                    we_o = 1'b1;
                    fl   = 1'b1;
                end
                OPC_MOV: begin
                    res  = b;
                    we_o = 1'b1;
                end
                OPC_LD: begin
                    res  = mdmem[b[5:0]];
                    we_o = 1'b1;
                end
                OPC_ST: begin
                    mdmem[b[5:0]] = a;
                end
                OPC_BCC: if (cond_holds(instr[7:4])) npc = b;
                default: begin
                end
            endcase
        end else begin
            case (opc)
                OPC_ADDI: begin
                    wide = {1'b0, a} + {1'b0, b};
                    res  = wide[XLEN-1:0];
                    c    = wide[XLEN];
                    v    = (a[11] == b[11]) && (res[11] != a[11]);
                    we_o = 1'b1;
                    fl   = 1'b1;
                end
                OPC_MOVI: begin
                    res  = b;
                    we_o = 1'b1;
                end
                OPC_BCCI: if (cond_holds({2'b00, instr[7:6]})) npc = mpc + b;
                default: begin
                end
            endcase
        end
        if (fl) begin
            mflags[FLAG_Z] = (res == '0);
            mflags[FLAG_N] = res[11];
            mflags[FLAG_C] = c;
            mflags[FLAG_V] = v;
        end
        if (we_o) mreg[rd_o] = res;
        wd_o = res;
        mpc  = npc;
    endtask

    // One random word, the mix of instruction kinds depends on the test
    function automatic logic [XLEN-1:0] gen_word(int kind);
        int w [8];
        int roll;
        int cat;
        case (kind)
            1:       w = '{60, 15, 0, 0, 0, 15, 0, 10};
            2:       w = '{15, 5, 0, 10, 25, 30, 10, 5};
            3:       w = '{10, 5, 40, 0, 15, 25, 0, 5};
            default: w = '{25, 5, 5, 20, 10, 10, 20, 5};
        endcase
        roll = int'($urandom % 100);
        cat  = 0;
        while (cat < 7 && roll >= w[cat]) begin
            roll -= w[cat];
            cat++;
        end
        case (cat)
            0: return {4'($urandom % 5), 4'($urandom % 4), 4'($urandom % 4)};
            1: return {OPC_MOV, 4'($urandom % 4), 4'($urandom % 4)};
            2: return {4'(6 + $urandom % 2), 4'($urandom % 4), 4'($urandom % 4)};
            3: return {OPC_BCC, 4'($urandom % 7), 4'($urandom % 4)};
            4: return {8'hF0, 4'($urandom % 2)};
            5: return {4'($urandom % 2), 8'($urandom)};
            6: return {OPC_BCCI, 8'($urandom)};
            default: return 12'($urandom);
        endcase
    endfunction

    task automatic run_test(string name, int nret);
        int              start_err;
        int              count;
        logic [XLEN-1:0] e_pc;
        logic [XLEN-1:0] e_instr;
        logic            e_we;
        logic [3:0]      e_rd;
        logic [XLEN-1:0] e_wd;
        start_err = errors;
        count     = 0;
        rst       = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) mreg[i] = '0;
        mflags = '0;
        miset  = ISET_R;
        mpc    = '0;
        for (int a = 0; a < LOAD_CYCLES; a++) begin
            @(posedge clk);
            #10;
            check_val("retire.valid in reset", {11'b0, retire.valid}, '0);
            imem_load = (a < IMEM_DEPTH);
            imem_addr = IMEM_AW'(a);
            imem_data = prog[a % 64];
        end
        @(posedge clk);
        #10;
        imem_load = 1'b0;
        rst       = 1'b0;
        while (count < nret) begin
            @(posedge clk);
            #10;
            if (retire.valid) begin
                model_step(e_pc, e_instr, e_we, e_rd, e_wd);
                check_val("retire.pc", retire.pc, e_pc);
                check_val("retire.instr", retire.instr, e_instr);
                check_val("retire.we", {11'b0, retire.we}, {11'b0, e_we});
                if (e_we) begin
                    check_val("retire.rd", {8'b0, retire.rd}, {8'b0, e_rd});
                    check_val("retire.wdata", retire.wdata, e_wd);
                end
                count++;
            end
        end
        $display("%s: %0d retired, %0d errors", name, count, errors - start_err);
    endtask

    initial begin
        void'($urandom(32'he156));
        rst       = 1'b1;
        imem_load = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        errors    = 0;
        checks    = 0;

        // Loop that stores each address to itself, so later loads see known data
        for (int i = 0; i < 64; i++) prog[i] = 12'hF00;
        prog[1] = 12'h711;
        prog[2] = 12'hF01;
        prog[3] = 12'h041;
        prog[4] = 12'h23C;
        run_test("mem_fill", MAX_RETIRE);

        for (int i = 0; i < 64; i++) prog[i] = gen_word(1);
        run_test("alu_deps", 300);
        for (int i = 0; i < 64; i++) prog[i] = gen_word(2);
        run_test("iset_sw", 300);
        for (int i = 0; i < 64; i++) prog[i] = gen_word(3);
        run_test("ld_st", 300);
        for (int i = 0; i < 64; i++) prog[i] = gen_word(4);
        run_test("branch", 300);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== henad_core.f ====
src/henad_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/reg_file.sv
src/execute_stage.sv
src/henad_core.sv
sim/henad_core_props.sv
sim/henad_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timing -f henad_core.f \
    --top-module henad_core_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vhenad_core_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi
